//--- common/rv_pkg.sv
package rv_pkg;

    // Data widths
    typedef logic [31:0] word_t;      // PC, instruction, register value, immediate
    typedef logic [3:0]  reg_idx_t;   // RV32E has 16 registers
    typedef logic [1:0]  bp_cnt_t;    // Saturating taken counter

    localparam word_t RESET_PC = 32'h0000_0000;

    // Branch target buffer geometry
    localparam int BTB_IDX_W   = 4;
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;   // PC bits above the index

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam word_t INST_EBREAK = 32'h0010_0073;

    // Branch compare selects
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;   // ADD vs SUB in OP

endpackage

//--- fetch/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::word_t fetch_pc,
    input  logic          bp_update,
    input  rv_pkg::word_t bp_pc,
    input  logic          bp_taken,
    input  rv_pkg::word_t bp_target,
    input  logic          bp_correct,
    output logic          pred_taken,
    output rv_pkg::word_t pred_target,
    output rv_pkg::word_t total_predictions,
    output rv_pkg::word_t correct_predictions
);
    import rv_pkg::*;

    logic                 btb_valid  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] btb_tag    [BTB_ENTRIES];
    word_t                btb_target [BTB_ENTRIES];
    bp_cnt_t              btb_cnt    [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] f_idx;
    logic [BTB_TAG_W-1:0] f_tag;
    logic                 f_hit;

    logic [BTB_IDX_W-1:0] u_idx;
    logic [BTB_TAG_W-1:0] u_tag;
    logic                 u_hit;

    // Lookup for the PC being fetched
    assign f_idx = fetch_pc[BTB_IDX_W+1:2];
    assign f_tag = fetch_pc[31:BTB_IDX_W+2];
    assign f_hit = btb_valid[f_idx] && (btb_tag[f_idx] == f_tag);

    assign pred_taken  = f_hit && btb_cnt[f_idx][1];   // Counter 2 or 3
    assign pred_target = btb_target[f_idx];

    // Same split for the resolved branch
    assign u_idx = bp_pc[BTB_IDX_W+1:2];
    assign u_tag = bp_pc[31:BTB_IDX_W+2];
    assign u_hit = btb_valid[u_idx] && (btb_tag[u_idx] == u_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
            total_predictions   <= '0;
            correct_predictions <= '0;
        end else if (bp_update) begin
            total_predictions <= total_predictions + 32'd1;
            if (bp_correct) begin
                correct_predictions <= correct_predictions + 32'd1;
            end
            if (bp_taken) begin
                btb_valid[u_idx] <= 1'b1;
            end
        end
    end

    // Tag, target and counter of the updated entry
    always_ff @(posedge clk) begin
        if (bp_update) begin
            if (bp_taken) begin
                btb_tag[u_idx]    <= u_tag;
                btb_target[u_idx] <= bp_target;
                if (!u_hit) begin
                    btb_cnt[u_idx] <= 2'd2;   // New entry starts weakly taken
                end else if (btb_cnt[u_idx] != 2'd3) begin
                    btb_cnt[u_idx] <= btb_cnt[u_idx] + 2'd1;
                end
            end else if (u_hit && (btb_cnt[u_idx] != 2'd0)) begin
                btb_cnt[u_idx] <= btb_cnt[u_idx] - 2'd1;
            end
        end
    end

endmodule

//--- fetch/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    input  logic          halted,
    input  logic          pred_taken,
    input  rv_pkg::word_t pred_target,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t fetch_pc,
    output logic          ex_valid,
    output rv_pkg::word_t ex_pc,
    output rv_pkg::word_t ex_inst,
    output logic          ex_pred_taken,
    output rv_pkg::word_t ex_pred_target
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    assign fetch_pc = pc;

    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;      // Execute found a mispredict
        end else if (halted) begin
            pc_next = pc;
        end else if (pred_taken) begin
            pc_next = pred_target;      // Follow the BTB
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= RESET_PC;
            ex_valid <= 1'b0;
        end else begin
            pc       <= pc_next;
            ex_valid <= !(redirect || halted);   // Squash the wrong-path fetch
        end
    end

    // The prediction rides along so execute can judge it
    always_ff @(posedge clk) begin
        ex_pc          <= pc;
        ex_inst        <= imem_data;
        ex_pred_taken  <= pred_taken;
        ex_pred_target <= pred_target;
    end

endmodule

//--- flist.f
common/rv_pkg.sv
fetch/fetch_unit.sv
fetch/branch_predictor.sv
logic/execute_unit.sv
logic/reg_file.sv
logic/rv32e_core.sv
sim/rv32e_core_sva.sv
sim/tb_rv32e_core.sv

//--- logic/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             ex_valid,
    input  rv_pkg::word_t    ex_pc,
    input  rv_pkg::word_t    ex_inst,
    input  logic             ex_pred_taken,
    input  rv_pkg::word_t    ex_pred_target,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output logic             wr_en,
    output rv_pkg::word_t    wr_pc,
    output rv_pkg::reg_idx_t wr_rd,
    output rv_pkg::word_t    wr_data,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc,
    output logic             bp_update,
    output rv_pkg::word_t    bp_pc,
    output logic             bp_taken,
    output rv_pkg::word_t    bp_target,
    output logic             bp_correct,
    output logic             halted
);
    import rv_pkg::*;

    logic       valid;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;

    logic       is_op_imm;
    logic       is_op;
    logic       is_branch;
    logic       is_jal;
    logic       is_ebreak;

    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      pc_plus4;
    word_t      alu_result;

    logic       src_equal;
    logic       taken;
    word_t      target;
    word_t      actual_next;
    word_t      pred_next;

    // An instruction that slipped in behind EBREAK never executes
    assign valid = ex_valid && !halted;

    // RV32E keeps only the low four bits of each register field
    assign opcode = ex_inst[6:0];
    assign funct3 = ex_inst[14:12];
    assign funct7 = ex_inst[31:25];
    assign rd     = ex_inst[10:7];
    assign rs1    = ex_inst[18:15];
    assign rs2    = ex_inst[23:20];

    assign is_op_imm = (opcode == OPC_OP_IMM);   // Treated as ADDI
    assign is_op     = (opcode == OPC_OP);       // ADD or SUB
    assign is_branch = (opcode == OPC_BRANCH) && ((funct3 == F3_BEQ) || (funct3 == F3_BNE));
    assign is_jal    = (opcode == OPC_JAL);
    assign is_ebreak = (opcode == OPC_SYSTEM) && (ex_inst == INST_EBREAK);

    // Immediates
    assign imm_i = {{20{ex_inst[31]}}, ex_inst[31:20]};
    assign imm_b = {{19{ex_inst[31]}}, ex_inst[31], ex_inst[7], ex_inst[30:25],
                    ex_inst[11:8], 1'b0};
    assign imm_j = {{11{ex_inst[31]}}, ex_inst[31], ex_inst[19:12], ex_inst[20],
                    ex_inst[30:21], 1'b0};

    assign pc_plus4 = ex_pc + 32'd4;

    always_comb begin
        if (is_op_imm) begin
            alu_result = rs1_data + imm_i;
        end else if (funct7 == F7_SUB) begin
            alu_result = rs1_data - rs2_data;
        end else begin
            alu_result = rs1_data + rs2_data;
        end
    end

    // Control flow resolution
    assign src_equal = (rs1_data == rs2_data);

    always_comb begin
        if (is_jal) begin
            taken  = 1'b1;
            target = ex_pc + imm_j;
        end else if (is_branch) begin
            taken  = (funct3 == F3_BEQ) ? src_equal : !src_equal;
            target = ex_pc + imm_b;
        end else begin
            taken  = 1'b0;
            target = pc_plus4;
        end
    end

    assign actual_next = taken ? target : pc_plus4;
    assign pred_next   = ex_pred_taken ? ex_pred_target : pc_plus4;

    assign redirect    = valid && (actual_next != pred_next);   // Flushes one fetch
    assign redirect_pc = actual_next;

    // Predictor training for every resolved branch and jump
    assign bp_update  = valid && (is_branch || is_jal);
    assign bp_pc      = ex_pc;
    assign bp_taken   = taken;
    assign bp_target  = target;
    assign bp_correct = (ex_pred_taken == taken) && (!taken || (ex_pred_target == target));

    // The register write doubles as the retire report
    assign wr_en = valid && (is_op_imm || is_op || is_branch || is_jal);
    assign wr_pc = ex_pc;
    assign wr_rd = is_branch ? 4'd0 : rd;

    always_comb begin
        if (is_jal) begin
            wr_data = pc_plus4;      // Return address
        end else if (is_branch) begin
            wr_data = '0;
        end else begin
            wr_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (valid && is_ebreak) begin
            halted <= 1'b1;          // Sticky until reset
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             wr_en,
    input  rv_pkg::word_t    wr_pc,
    input  rv_pkg::reg_idx_t wr_rd,
    input  rv_pkg::word_t    wr_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    output logic             retire_valid,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_data
);
    import rv_pkg::*;

    word_t regs [16];

    // x0 is cleared by reset and never written
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            retire_valid <= 1'b0;
        end else begin
            if (wr_en && (wr_rd != 4'd0)) begin
                regs[wr_rd] <= wr_data;
            end
            retire_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= wr_pc;
        retire_rd   <= wr_rd;
        retire_data <= (wr_rd == 4'd0) ? 32'd0 : wr_data;   // x0 always reads zero
    end

endmodule

//--- logic/rv32e_core.sv
`timescale 1ns/1ns

module rv32e_core (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    imem_data,
    output rv_pkg::word_t    imem_addr,
    output logic             retire_valid,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_data,
    output logic             halted,
    output rv_pkg::word_t    total_predictions,
    output rv_pkg::word_t    correct_predictions
);
    import rv_pkg::*;

    // Fetch to execute
    word_t    fetch_pc;
    logic     ex_valid;
    word_t    ex_pc;
    word_t    ex_inst;
    logic     ex_pred_taken;
    word_t    ex_pred_target;

    // Predictor
    logic     pred_taken;
    word_t    pred_target;
    logic     bp_update;
    word_t    bp_pc;
    logic     bp_taken;
    word_t    bp_target;
    logic     bp_correct;

    // Execute back to fetch
    logic     redirect;
    word_t    redirect_pc;

    // Register file
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     wr_en;
    word_t    wr_pc;
    reg_idx_t wr_rd;
    word_t    wr_data;

    assign imem_addr = fetch_pc;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .reset          (reset),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .imem_data      (imem_data),
        .fetch_pc       (fetch_pc),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_inst        (ex_inst),
        .ex_pred_taken  (ex_pred_taken),
        .ex_pred_target (ex_pred_target)
    );

    branch_predictor i_branch_predictor (
        .clk                 (clk),
        .reset               (reset),
        .fetch_pc            (fetch_pc),
        .bp_update           (bp_update),
        .bp_pc               (bp_pc),
        .bp_taken            (bp_taken),
        .bp_target           (bp_target),
        .bp_correct          (bp_correct),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .total_predictions   (total_predictions),
        .correct_predictions (correct_predictions)
    );

    execute_unit i_execute_unit (
        .clk            (clk),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_inst        (ex_inst),
        .ex_pred_taken  (ex_pred_taken),
        .ex_pred_target (ex_pred_target),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .rs1            (rs1),
        .rs2            (rs2),
        .wr_en          (wr_en),
        .wr_pc          (wr_pc),
        .wr_rd          (wr_rd),
        .wr_data        (wr_data),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .bp_update      (bp_update),
        .bp_pc          (bp_pc),
        .bp_taken       (bp_taken),
        .bp_target      (bp_target),
        .bp_correct     (bp_correct),
        .halted         (halted)
    );

    reg_file i_reg_file (
        .clk          (clk),
        .reset        (reset),
        .rs1          (rs1),
        .rs2          (rs2),
        .wr_en        (wr_en),
        .wr_pc        (wr_pc),
        .wr_rd        (wr_rd),
        .wr_data      (wr_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

//--- sim/program_stim.txt
# I <byte address> <instruction word>
# R <retire pc> <rd> <data> in retire order, P <total predictions> <correct predictions>
I 00 00500093
I 04 00300113
I 08 002081b3
I 0c 40208233
I 10 00708013
I 14 000002b3
I 18 00300313
I 1c 00138393
I 20 fff30313
I 24 fe031ce3
I 28 00208463
I 2c 0080046f
I 30 06300493
I 34 00318463
I 38 04d00513
I 3c 00140593
I 40 00100073
I 44 00100613
R 00 1 00000005
R 04 2 00000003
R 08 3 00000008
R 0c 4 00000002
R 10 0 00000000
R 14 5 00000000
R 18 6 00000003
R 1c 7 00000001
R 20 6 00000002
R 24 0 00000000
R 1c 7 00000002
R 20 6 00000001
R 24 0 00000000
R 1c 7 00000003
R 20 6 00000000
R 24 0 00000000
R 28 0 00000000
R 2c 8 00000030
R 34 0 00000000
R 3c b 00000031
P 6 2

//--- sim/rv32e_core_sva.sv
`timescale 1ns/1ns

module rv32e_core_sva (
    input logic          clk,
    input logic          reset,
    input logic          retire_valid,
    input logic          halted,
    input rv_pkg::word_t total_predictions,
    input rv_pkg::word_t correct_predictions
);

    int fail_count = 0;   // Polled by the testbench

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) reset |=> !retire_valid)
        else begin
            $error("retire_valid high in the cycle after reset");
            fail_count++;
        end

    counters_ordered: assert property (@(posedge clk) disable iff (reset)
                                       correct_predictions <= total_predictions)
        else begin
            $error("correct_predictions exceeds total_predictions");
            fail_count++;
        end

    // EBREAK never writes and later instructions are squashed
    no_retire_after_halt: assert property (@(posedge clk) disable iff (reset)
                                           halted |-> ##2 !retire_valid)
        else begin
            $error("retire_valid high two cycles after halted");
            fail_count++;
        end

endmodule

//--- sim/tb_rv32e_core.sv
`timescale 1ns/1ns

module tb_rv32e_core;
    import rv_pkg::*;

    localparam int ROM_WORDS    = 256;
    localparam int HALT_TIMEOUT = 2000;   // Cycles
    localparam int DRAIN_CYCLES = 20;

    logic     clk;
    logic     reset;
    word_t    imem_addr;
    word_t    imem_data;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    word_t    retire_data;
    logic     halted;
    word_t    total_predictions;
    word_t    correct_predictions;

    word_t    rom [ROM_WORDS];
    word_t    exp_pc_q [$];
    reg_idx_t exp_rd_q [$];
    word_t    exp_data_q [$];
    word_t    exp_total;
    word_t    exp_correct;
    int       retire_count = 0;
    int       expected_retires;

    rv32e_core i_rv32e_core (
        .clk                 (clk),
        .reset               (reset),
        .imem_data           (imem_data),
        .imem_addr           (imem_addr),
        .retire_valid        (retire_valid),
        .retire_pc           (retire_pc),
        .retire_rd           (retire_rd),
        .retire_data         (retire_data),
        .halted              (halted),
        .total_predictions   (total_predictions),
        .correct_predictions (correct_predictions)
    );

    bind rv32e_core rv32e_core_sva i_rv32e_core_sva (
        .clk                 (clk),
        .reset               (reset),
        .retire_valid        (retire_valid),
        .halted              (halted),
        .total_predictions   (total_predictions),
        .correct_predictions (correct_predictions)
    );

    // Instruction memory answers within the fetch cycle
    assign imem_data = rom[imem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t actual,
                             input reg_idx_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic load_stim();
        int         fd;
        int         code;
        logic [7:0] kind;
        string      line;
        word_t      addr;
        word_t      data;
        reg_idx_t   rd;
        bit         saw_p;
        saw_p = 1'b0;
        fd = $fopen("sim/program_stim.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open sim/program_stim.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
                case (kind)
                    "#": code = $fgets(line, fd);   // Rest of a comment line
                    "I": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        if (code != 2) report_failure("malformed I line in stim file");
                        rom[addr[9:2]] = data;
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", addr, rd, data);
                        if (code != 3) report_failure("malformed R line in stim file");
                        exp_pc_q.push_back(addr);
                        exp_rd_q.push_back(rd);
                        exp_data_q.push_back(data);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", exp_total, exp_correct);
                        if (code != 2) report_failure("malformed P line in stim file");
                        saw_p = 1'b1;
                    end
                    default: report_failure("unknown line kind in stim file");
                endcase
            end
        end
        $fclose(fd);
        if (!saw_p) begin
            report_failure("stim file has no P line");
        end
        expected_retires = exp_pc_q.size();
    endtask

    // Compare one retire report with the head of the expected trace
    task automatic match_retire();
        if (exp_pc_q.size() == 0) begin
            report_failure($sformatf("retire of pc 0x%08h beyond the expected trace",
                                     retire_pc));
        end
        check_word("retire_pc", retire_pc, exp_pc_q.pop_front());
        check_reg("retire_rd", retire_rd, exp_rd_q.pop_front());
        check_word("retire_data", retire_data, exp_data_q.pop_front());
        retire_count++;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles == HALT_TIMEOUT) begin
                report_failure("core did not halt before timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (reset === 1'b0 && retire_valid === 1'b1) begin
            match_retire();
        end
    end

    always @(negedge clk) begin
        if (i_rv32e_core.i_rv32e_core_sva.fail_count != 0) begin
            report_failure("an assertion in rv32e_core_sva failed");
        end
    end

    initial begin
        reset = 1'b1;
        load_stim();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("halted", halted, 1'b0);
        check_word("total_predictions", total_predictions, 32'd0);
        check_word("correct_predictions", correct_predictions, 32'd0);

        wait_for_halt();
        repeat (DRAIN_CYCLES) @(negedge clk);   // Nothing may retire after the halt

        check_word("retire count", retire_count, expected_retires);
        check_word("total_predictions", total_predictions, exp_total);
        check_word("correct_predictions", correct_predictions, exp_correct);

        if (i_rv32e_core.i_rv32e_core_sva.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("an assertion in rv32e_core_sva failed");
        end
    end

endmodule
